// File: compile.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/wb_intercon.sv
hdl/block_ram.sv
hdl/simple_pic.sv
hdl/simple_gpio.sv
hdl/system.sv
sim/system_checker.sv
sim/tb_system.sv

// File: Makefile
# Verilator build and run of the Wishbone subsystem testbench

TOP := tb_system

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

# Pass only if the simulation printed the pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: sim/tb_system.sv
// ----------------------------------------
// Random test of the Wishbone subsystem
// RAM is filled first so partial writes are checkable
// Run ends after 20000 cycles at the latest
// ----------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_system;
    import soc_pkg::*;

    localparam int          MAX_CYCLES = 20000;
    localparam int          RAM_WORDS  = 1 << `SOC_RAM_ADDR_W;
    localparam logic [15:0] PIC_BASE   = 16'h1000;
    localparam logic [15:0] GPIO_BASE  = 16'h2000;

    logic                       sys_clk;
    logic                       reset;
    wb_req_t                    req;
    wb_rsp_t                    rsp;
    logic [`SOC_IRQ_W-1:0]      irq;
    logic                       int_out;
    logic [`SOC_GPIO_W-1:0]     gpio_in;
    logic [`SOC_GPIO_W-1:0]     gpio_out;
    logic [`SOC_GPIO_W-1:0]     gpio_oe;

    integer                     seed;
    int                         cycles;
    int                         checks;
    int                         errors;
    int                         errors_before;
    logic [31:0]                rnd;
    logic [31:0]                wdat;
    logic [31:0]                rd_data;
    logic                       got_ack;
    logic                       got_err;
    logic [3:0]                 slv;
    logic [`SOC_RAM_ADDR_W-1:0] widx;
    logic [15:0]                adr;
    logic [`SOC_IRQ_W-1:0]      hold;

    // Reference model state
    logic [31:0]                ram_model [0:RAM_WORDS-1];
    logic [`SOC_IRQ_W-1:0]      pend_m;
    logic [`SOC_IRQ_W-1:0]      mask_m;

    system u_dut (
        .sys_clk_i (sys_clk),
        .reset_i   (reset),
        .wb_req_i  (req),
        .wb_rsp_o  (rsp),
        .irq_i     (irq),
        .int_o     (int_out),
        .gpio_i    (gpio_in),
        .gpio_o    (gpio_out),
        .gpio_oe_o (gpio_oe)
    );

    bind system system_checker u_checker (
        .sys_clk_i (sys_clk_i),
        .reset_i   (reset_i),
        .wb_req_i  (wb_req_i),
        .wb_rsp_i  (wb_rsp_o)
    );

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;

    // Watchdog at about four times the bus traffic
    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a bus access never completed", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // ----------------------------------------
    // Bus master
    // ----------------------------------------
    // One access with the response expected on the second edge after the drive
    task automatic bus_access(input logic [15:0] a, input logic [31:0] d,
                              input logic [3:0] s, input logic w);
        int edges;
        edges = 0;
        @(posedge sys_clk);
        req <= '{adr: a, dat: d, sel: s, we: w, cyc: 1'b1, stb: 1'b1};
        do begin
            @(posedge sys_clk);
            edges++;
        end while (!(rsp.ack || rsp.err));
        got_ack = rsp.ack;
        got_err = rsp.err;
        rd_data = rsp.dat;
        // Idle for one cycle before the next access
        req.cyc <= 1'b0;
        req.stb <= 1'b0;
        checks++;
        if (edges != 2) begin
            errors++;
            $display("Response to address %h came %0d cycles after the request, not 1",
                     a, edges - 1);
        end
    endtask

    task automatic write_word(input logic [15:0] a, input logic [31:0] d,
                              input logic [3:0] s);
        bus_access(a, d, s, 1'b1);
        check_word("wb_rsp_o.ack", 32'd1, 32'(got_ack));
    endtask

    task automatic read_expect(input logic [15:0] a, input logic [31:0] exp);
        bus_access(a, 32'd0, 4'hF, 1'b0);
        check_word("wb_rsp_o.ack", 32'd1, 32'(got_ack));
        check_word("wb_rsp_o.dat", exp, rd_data);
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        seed          = 32'h7530;
        checks        = 0;
        errors        = 0;
        errors_before = 0;
        reset         = 1'b1;
        req           = '0;
        irq           = '0;
        gpio_in       = '0;
        pend_m        = '0;
        mask_m        = '0;
        repeat (10) @(posedge sys_clk);
        reset <= 1'b0;
        @(posedge sys_clk);

        // Outputs and registers cleared by reset
        check_word("wb_rsp_o.ack", 32'd0, 32'(rsp.ack));
        check_word("wb_rsp_o.err", 32'd0, 32'(rsp.err));
        check_word("int_o", 32'd0, 32'(int_out));
        check_word("gpio_o", 32'd0, 32'(gpio_out));
        check_word("gpio_oe_o", 32'd0, 32'(gpio_oe));
        for (int r = 0; r < 3; r++) begin
            read_expect(PIC_BASE + 16'(r * 4), 32'd0);
        end
        for (int r = 0; r < 4; r++) begin
            read_expect(GPIO_BASE + 16'(r * 4), 32'd0);
        end
        finish_test("reset");

        // Select field 3 to 15 answers with err and zero data
        for (int i = 0; i < 30; i++) begin
            rnd = $random(seed);
            slv = 4'(3 + rnd[7:0] % 13);
            bus_access({slv, rnd[11:0]}, rnd, rnd[15:12], rnd[16]);
            check_word("wb_rsp_o.ack", 32'd0, 32'(got_ack));
            check_word("wb_rsp_o.err", 32'd1, 32'(got_err));
            check_word("wb_rsp_o.dat", 32'd0, rd_data);
        end
        finish_test("unmapped");

        // Full-word fill with a pattern from the byte address
        for (int w = 0; w < RAM_WORDS; w++) begin
            adr          = 16'(w * 4);
            ram_model[w] = {~adr, adr ^ 16'h5A5A};
            write_word(adr, ram_model[w], 4'hF);
        end
        for (int i = 0; i < 200; i++) begin
            rnd  = $random(seed);
            wdat = $random(seed);
            widx = rnd[`SOC_RAM_ADDR_W-1:0];
            write_word({4'h0, widx, 2'b00}, wdat, rnd[13:10]);
            for (int b = 0; b < 4; b++) begin
                if (rnd[10 + b]) begin
                    ram_model[widx][b*8 +: 8] = wdat[b*8 +: 8];
                end
            end
            read_expect({4'h0, widx, 2'b00}, ram_model[widx]);
            // Some other word to catch stray writes
            widx = rnd[29:20];
            read_expect({4'h0, widx, 2'b00}, ram_model[widx]);
        end
        finish_test("ram");

        for (int i = 0; i < 16; i++) begin
            rnd  = $random(seed);
            wdat = $random(seed);
            write_word(GPIO_BASE, rnd, 4'hF);
            check_word("gpio_o", 32'(rnd[`SOC_GPIO_W-1:0]), 32'(gpio_out));
            write_word(GPIO_BASE + 16'h4, wdat, 4'hF);
            check_word("gpio_oe_o", 32'(wdat[`SOC_GPIO_W-1:0]), 32'(gpio_oe));
            read_expect(GPIO_BASE, 32'(rnd[`SOC_GPIO_W-1:0]));
            read_expect(GPIO_BASE + 16'h4, 32'(wdat[`SOC_GPIO_W-1:0]));
            // Input held three cycles through the synchroniser
            @(posedge sys_clk);
            gpio_in <= rnd[23:16];
            repeat (3) @(posedge sys_clk);
            read_expect(GPIO_BASE + 16'h8, 32'(rnd[23:16]));
        end
        read_expect(GPIO_BASE + 16'hC, 32'd0);
        finish_test("gpio");

        for (int i = 0; i < 8; i++) begin
            rnd    = $random(seed);
            mask_m = rnd[`SOC_IRQ_W-1:0];
            write_word(PIC_BASE + 16'h4, rnd, 4'hF);
            // Sparse one-cycle irq patterns
            for (int k = 0; k < 6; k++) begin
                rnd = $random(seed);
                @(posedge sys_clk);
                irq <= rnd[7:0] & rnd[15:8] & rnd[23:16];
                @(posedge sys_clk);
                irq    <= '0;
                pend_m = pend_m | (rnd[7:0] & rnd[15:8] & rnd[23:16]);
                @(posedge sys_clk);
                check_word("int_o", 32'(|(pend_m & mask_m)), 32'(int_out));
            end
            read_expect(PIC_BASE, 32'(pend_m));
            read_expect(PIC_BASE + 16'h4, 32'(mask_m));
            read_expect(PIC_BASE + 16'h8, 32'(pend_m & mask_m));

            // Clear with irq lines high only on the edge that takes the write
            rnd  = $random(seed);
            hold = rnd[15:8] & rnd[23:16];
            fork
                write_word(PIC_BASE, rnd, 4'hF);
                begin
                    @(posedge sys_clk);
                    irq <= hold;
                    @(posedge sys_clk);
                    irq <= '0;
                end
            join
            pend_m = (pend_m & ~rnd[7:0]) | hold;
            // Register 2 is read-only
            write_word(PIC_BASE + 16'h8, ~rnd, 4'hF);
            read_expect(PIC_BASE, 32'(pend_m));
            read_expect(PIC_BASE + 16'h8, 32'(pend_m & mask_m));
            check_word("int_o", 32'(|(pend_m & mask_m)), 32'(int_out));
        end
        finish_test("pic");

        errors += u_dut.u_checker.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim/system_checker.sv
// ----------------------------------------
// Handshake properties of the external bus
// Bound into system, samples on sys_clk_i
// ----------------------------------------
`timescale 1ns/1ps

module system_checker (
    input logic             sys_clk_i,
    input logic             reset_i,
    input soc_pkg::wb_req_t wb_req_i,
    input soc_pkg::wb_rsp_t wb_rsp_i
);
    import soc_pkg::*;

    // Failed properties so far, read by the testbench at the end
    int fail_count;

    // Never both responses at once
    a_ack_err_exclusive: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        !(wb_rsp_i.ack && wb_rsp_i.err))
        else begin
            fail_count++;
            $error("ack and err high in the same cycle");
        end

    // A response needs a valid strobe one cycle earlier
    a_rsp_after_stb: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        (wb_rsp_i.ack || wb_rsp_i.err) |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else begin
            fail_count++;
            $error("response without a strobe in the cycle before");
        end

    // Single-cycle ack pulse
    a_ack_single: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack high for two cycles in a row");
        end

endmodule

// File: hdl/system.sv
// --------------------------------------
// Wishbone subsystem top, one external master
// Slave regions RAM 0x0000, PIC 0x1000, GPIO 0x2000
// --------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module system (
    input  logic                   sys_clk_i,
    input  logic                   reset_i,
    input  soc_pkg::wb_req_t       wb_req_i,
    output soc_pkg::wb_rsp_t       wb_rsp_o,
    input  logic [`SOC_IRQ_W-1:0]  irq_i,
    output logic                   int_o,
    input  logic [`SOC_GPIO_W-1:0] gpio_i,
    output logic [`SOC_GPIO_W-1:0] gpio_o,
    output logic [`SOC_GPIO_W-1:0] gpio_oe_o
);
    import soc_pkg::*;

    // Slave side buses
    wb_req_t ram_req;
    wb_req_t pic_req;
    wb_req_t gpio_req;
    wb_rsp_t ram_rsp;
    wb_rsp_t pic_rsp;
    wb_rsp_t gpio_rsp;

    // ----------------------------------------
    // Interconnect
    // ----------------------------------------
    wb_intercon u_intercon (
        .sys_clk_i  (sys_clk_i),
        .reset_i    (reset_i),
        .m_req_i    (wb_req_i),
        .m_rsp_o    (wb_rsp_o),
        .ram_req_o  (ram_req),
        .pic_req_o  (pic_req),
        .gpio_req_o (gpio_req),
        .ram_rsp_i  (ram_rsp),
        .pic_rsp_i  (pic_rsp),
        .gpio_rsp_i (gpio_rsp)
    );

    // ----------------------------------------
    // Slaves
    // ----------------------------------------
    // 4 kB data memory
    block_ram u_dmem (
        .sys_clk_i (sys_clk_i),
        .reset_i   (reset_i),
        .wb_req_i  (ram_req),
        .wb_rsp_o  (ram_rsp)
    );

    // Interrupt sources come straight from the pins
    simple_pic u_pic (
        .sys_clk_i (sys_clk_i),
        .reset_i   (reset_i),
        .wb_req_i  (pic_req),
        .wb_rsp_o  (pic_rsp),
        .irq_i     (irq_i),
        .int_o     (int_o)
    );

    simple_gpio u_gpio (
        .sys_clk_i (sys_clk_i),
        .reset_i   (reset_i),
        .wb_req_i  (gpio_req),
        .wb_rsp_o  (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

endmodule

// File: hdl/simple_gpio.sv
// --------------------------------------
// GPIO with separate in, out and enable pins
// gpio_i is asynchronous, two flops before the bus
// Full-word register writes, sel is not decoded
// --------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module simple_gpio (
    input  logic                   sys_clk_i,
    input  logic                   reset_i,
    input  soc_pkg::wb_req_t       wb_req_i,
    output soc_pkg::wb_rsp_t       wb_rsp_o,
    input  logic [`SOC_GPIO_W-1:0] gpio_i,
    output logic [`SOC_GPIO_W-1:0] gpio_o,
    output logic [`SOC_GPIO_W-1:0] gpio_oe_o
);
    import soc_pkg::*;

    // Register map, index 3 reads zero
    localparam reg_idx_t REG_OUT = 2'd0;
    localparam reg_idx_t REG_DIR = 2'd1;
    localparam reg_idx_t REG_IN  = 2'd2;

    reg_idx_t               idx;
    logic                   access;
    logic                   wr;
    logic                   ack_q;
    logic [`SOC_GPIO_W-1:0] out_q;
    logic [`SOC_GPIO_W-1:0] dir_q;
    logic [`SOC_GPIO_W-1:0] sync1_q;
    logic [`SOC_GPIO_W-1:0] sync2_q;
    logic [`SOC_DATA_W-1:0] rd_d;
    logic [`SOC_DATA_W-1:0] rd_q;

    assign idx    = wb_reg_idx(wb_req_i);
    assign access = wb_strobe(wb_req_i) & ~ack_q;
    assign wr     = access & wb_req_i.we;

    always_comb begin
        rd_d = '0;
        case (idx)
            REG_OUT: rd_d[`SOC_GPIO_W-1:0] = out_q;
            REG_DIR: rd_d[`SOC_GPIO_W-1:0] = dir_q;
            REG_IN:  rd_d[`SOC_GPIO_W-1:0] = sync2_q;
            default: rd_d = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            out_q   <= '0;
            dir_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            rd_q    <= '0;
        end else begin
            ack_q   <= access;
            // Input synchroniser
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            if (wr && idx == REG_OUT) begin
                out_q <= wb_req_i.dat[`SOC_GPIO_W-1:0];
            end
            if (wr && idx == REG_DIR) begin
                dir_q <= wb_req_i.dat[`SOC_GPIO_W-1:0];
            end
            if (access) begin
                rd_q <= rd_d;
            end
        end
    end

    // Direction bit 1 drives the pin
    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

    assign wb_rsp_o.dat = rd_q;
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;

endmodule

// File: hdl/simple_pic.sv
// --------------------------------------
// Interrupt controller with sticky pending bits
// Level irq inputs, synchronous to sys_clk_i
// Full-word register writes, sel is not decoded
// --------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module simple_pic (
    input  logic                  sys_clk_i,
    input  logic                  reset_i,
    input  soc_pkg::wb_req_t      wb_req_i,
    output soc_pkg::wb_rsp_t      wb_rsp_o,
    input  logic [`SOC_IRQ_W-1:0] irq_i,
    output logic                  int_o
);
    import soc_pkg::*;

    // Register map
    localparam reg_idx_t REG_PEND   = 2'd0;
    localparam reg_idx_t REG_MASK   = 2'd1;
    localparam reg_idx_t REG_ACTIVE = 2'd2;

    reg_idx_t               idx;
    logic                   access;
    logic                   wr;
    logic                   ack_q;
    logic [`SOC_IRQ_W-1:0]  pending_q;
    logic [`SOC_IRQ_W-1:0]  mask_q;
    logic [`SOC_IRQ_W-1:0]  clr;
    logic [`SOC_IRQ_W-1:0]  active;
    logic [`SOC_DATA_W-1:0] rd_d;
    logic [`SOC_DATA_W-1:0] rd_q;

    assign idx    = wb_reg_idx(wb_req_i);
    assign access = wb_strobe(wb_req_i) & ~ack_q;
    assign wr     = access & wb_req_i.we;

    // Write 1 to clear pending
    assign clr    = (wr && idx == REG_PEND) ? wb_req_i.dat[`SOC_IRQ_W-1:0] : '0;
    assign active = pending_q & mask_q;
    assign int_o  = |active;

    // Read mux, upper bits zero
    always_comb begin
        rd_d = '0;
        case (idx)
            REG_PEND:   rd_d[`SOC_IRQ_W-1:0] = pending_q;
            REG_MASK:   rd_d[`SOC_IRQ_W-1:0] = mask_q;
            REG_ACTIVE: rd_d[`SOC_IRQ_W-1:0] = active;
            default:    rd_d = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            pending_q <= '0;
            mask_q    <= '0;
            rd_q      <= '0;
        end else begin
            ack_q     <= access;
            // Set wins over clear in the same cycle
            pending_q <= (pending_q & ~clr) | irq_i;
            if (wr && idx == REG_MASK) begin
                mask_q <= wb_req_i.dat[`SOC_IRQ_W-1:0];
            end
            if (access) begin
                rd_q <= rd_d;
            end
        end
    end

    assign wb_rsp_o.dat = rd_q;
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;

endmodule

// File: hdl/block_ram.sv
// --------------------------------------
// 1024 x 32 data memory on Wishbone
// Contents are not cleared by reset
// Ack one cycle after the request, never err
// --------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module block_ram (
    input  logic             sys_clk_i,
    input  logic             reset_i,
    input  soc_pkg::wb_req_t wb_req_i,
    output soc_pkg::wb_rsp_t wb_rsp_o
);
    import soc_pkg::*;

    localparam int DEPTH  = 1 << `SOC_RAM_ADDR_W;
    localparam int BYTE_W = `SOC_DATA_W / `SOC_SEL_W;

    logic [`SOC_DATA_W-1:0]     mem [0:DEPTH-1];
    logic [`SOC_RAM_ADDR_W-1:0] word_idx;
    logic                       access;
    logic                       ack_q;
    logic [`SOC_DATA_W-1:0]     rd_q;

    // Word index from bits 11:2, byte offset ignored
    assign word_idx = wb_req_i.adr[`SOC_RAM_ADDR_W+1:2];

    // First cycle of a request only
    assign access = wb_strobe(wb_req_i) & ~ack_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // ----------------------------------------
    // Memory array
    // ----------------------------------------
    always_ff @(posedge sys_clk_i) begin
        if (access) begin
            if (wb_req_i.we) begin
                // Byte lanes with sel set
                for (int b = 0; b < `SOC_SEL_W; b++) begin
                    if (wb_req_i.sel[b]) begin
                        mem[word_idx][b*BYTE_W +: BYTE_W] <= wb_req_i.dat[b*BYTE_W +: BYTE_W];
                    end
                end
            end
            // Full word, returned together with ack
            rd_q <= mem[word_idx];
        end
    end

    assign wb_rsp_o.dat = rd_q;
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.err = 1'b0;

endmodule

// File: hdl/wb_intercon.sv
// --------------------------------------
// Single-master Wishbone decoder and response mux
// Select field 3 to 15 answers with err after one cycle
// Master must hold the request until ack or err
// --------------------------------------
`timescale 1ns/1ps
`include "soc_settings.svh"

module wb_intercon (
    input  logic             sys_clk_i,
    input  logic             reset_i,
    input  soc_pkg::wb_req_t m_req_i,
    output soc_pkg::wb_rsp_t m_rsp_o,
    output soc_pkg::wb_req_t ram_req_o,
    output soc_pkg::wb_req_t pic_req_o,
    output soc_pkg::wb_req_t gpio_req_o,
    input  soc_pkg::wb_rsp_t ram_rsp_i,
    input  soc_pkg::wb_rsp_t pic_rsp_i,
    input  soc_pkg::wb_rsp_t gpio_rsp_i
);
    import soc_pkg::*;

    slv_sel_t slv;
    logic     hit_ram;
    logic     hit_pic;
    logic     hit_gpio;
    logic     unmapped;
    logic     err_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign slv      = m_req_i.adr[`SOC_SLAVE_MSB:`SOC_SLAVE_LSB];
    assign hit_ram  = (slv == `SOC_SLV_RAM);
    assign hit_pic  = (slv == `SOC_SLV_PIC);
    assign hit_gpio = (slv == `SOC_SLV_GPIO);
    assign unmapped = ~(hit_ram | hit_pic | hit_gpio);

    // Shared address, data and sel; only cyc and stb are steered
    always_comb begin
        ram_req_o      = m_req_i;
        ram_req_o.cyc  = m_req_i.cyc & hit_ram;
        ram_req_o.stb  = m_req_i.stb & hit_ram;

        pic_req_o      = m_req_i;
        pic_req_o.cyc  = m_req_i.cyc & hit_pic;
        pic_req_o.stb  = m_req_i.stb & hit_pic;

        gpio_req_o     = m_req_i;
        gpio_req_o.cyc = m_req_i.cyc & hit_gpio;
        gpio_req_o.stb = m_req_i.stb & hit_gpio;
    end

    // ----------------------------------------
    // Error responder for unmapped regions
    // ----------------------------------------
    // One-cycle pulse, self-clearing like a slave ack
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= wb_strobe(m_req_i) & unmapped & ~err_q;
        end
    end

    // ----------------------------------------
    // Response mux
    // ----------------------------------------
    // Address is still held while the response is up
    always_comb begin
        case (slv)
            `SOC_SLV_RAM:  m_rsp_o = ram_rsp_i;
            `SOC_SLV_PIC:  m_rsp_o = pic_rsp_i;
            `SOC_SLV_GPIO: m_rsp_o = gpio_rsp_i;
            default: begin
                // No slave here, data reads as zero
                m_rsp_o     = '0;
                m_rsp_o.err = err_q;
            end
        endcase
    end

endmodule

// File: hdl/soc_pkg.sv
// --------------------------------------
// Wishbone types shared by the subsystem
// Classic single-cycle handshake only, no bursts and no rty
// --------------------------------------
`include "soc_settings.svh"

package soc_pkg;

    // Slave select field of a byte address
    typedef logic [`SOC_SLAVE_MSB-`SOC_SLAVE_LSB:0] slv_sel_t;

    // Register word index inside a peripheral region
    typedef logic [1:0] reg_idx_t;

    // Master to slave
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] adr;
        logic [`SOC_DATA_W-1:0] dat;
        logic [`SOC_SEL_W-1:0]  sel;
        logic                   we;
        logic                   cyc;
        logic                   stb;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] dat;
        logic                   ack;
        logic                   err;
    } wb_rsp_t;

    // Valid bus cycle in progress
    function automatic logic wb_strobe(wb_req_t req);
        return req.cyc & req.stb;
    endfunction

    // Word index from address bits 3:2
    function automatic reg_idx_t wb_reg_idx(wb_req_t req);
        return req.adr[3:2];
    endfunction

endpackage

// File: hdl/soc_settings.svh
// --------------------------------------
// Sizes and address map of the subsystem
// Byte addresses on a 32-bit bus, 4 kB per slave region
// --------------------------------------
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_ADDR_W      16
`define SOC_DATA_W      32
`define SOC_SEL_W       4

// Slave select field in the top nibble
`define SOC_SLAVE_MSB   15
`define SOC_SLAVE_LSB   12

// Data memory word index, 1024 words
`define SOC_RAM_ADDR_W  10

// Peripheral sizes
`define SOC_IRQ_W       8
`define SOC_GPIO_W      8

// Slave numbers in the select field
`define SOC_SLV_RAM     4'd0
`define SOC_SLV_PIC     4'd1
`define SOC_SLV_GPIO    4'd2

`endif
